/* uart_rx_pkg.sv */
package uart_rx_pkg;

    // ------------------------------------------------------------------------
    // line format and oversampling
    // ------------------------------------------------------------------------

    localparam int OVERSAMPLE = 16;      // ticks per bit

    typedef struct packed {
        logic       parity_en;
        logic       parity_type;         // 0 even, 1 odd
        logic       stop_bits;           // 0 one, 1 two
        logic [1:0] data_bits;           // 5 + code data bits
    } uart_cfg_t;

    // ------------------------------------------------------------------------
    // received frame
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [7:0] data;                // upper bits zero for short frames
        logic       parity_err;
        logic       stop_err;
    } rx_frame_t;

    // ------------------------------------------------------------------------
    // fifo trigger level
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        TRIG_1         = 2'd0,           // one entry
        TRIG_QUARTER   = 2'd1,           // DEPTH/4
        TRIG_HALF      = 2'd2,           // DEPTH/2
        TRIG_NEAR_FULL = 2'd3            // DEPTH-2
    } trig_level_t;

endpackage

/* uart_receiver.sv */
module uart_receiver
    import uart_rx_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      rx_en_i,
    input  logic      tick_i,
    input  uart_cfg_t cfg_i,
    input  logic      rx_i,
    output rx_frame_t frame_o,
    output logic      frame_valid_o
);

    localparam int            TW        = $clog2(OVERSAMPLE);
    localparam logic [TW-1:0] MID_START = TW'(OVERSAMPLE / 2 - 1);
    localparam logic [TW-1:0] MID_BIT   = TW'(OVERSAMPLE - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } state_t;

    state_t        state;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    logic [2:0]    last_bit;
    logic          stop_cnt;
    logic          rx_q;
    uart_cfg_t     cfg_q;              // format held for the whole frame
    logic [7:0]    shreg;
    logic          par_acc;
    logic          par_err;
    logic          stop_err;
    logic          bit_tick;

    assign last_bit = 3'd4 + {1'b0, cfg_q.data_bits};
    assign bit_tick = tick_i && (tick_cnt == MID_BIT);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_q <= 1'b1;                  // line idles high
        end else begin
            rx_q <= rx_i;
        end
    end

    // ------------------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= ST_IDLE;
            tick_cnt      <= '0;
            bit_cnt       <= '0;
            stop_cnt      <= 1'b0;
            cfg_q         <= '0;
            shreg         <= '0;
            par_acc       <= 1'b0;
            par_err       <= 1'b0;
            stop_err      <= 1'b0;
            frame_valid_o <= 1'b0;
            frame_o       <= '0;
        end else begin
            frame_valid_o <= 1'b0;
            if (tick_i) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    tick_cnt <= '0;
                    if (rx_en_i && rx_q && !rx_i) begin  // falling edge
                        state    <= ST_START;
                        cfg_q    <= cfg_i;
                        shreg    <= '0;
                        bit_cnt  <= '0;
                        stop_cnt <= 1'b0;
                        par_acc  <= 1'b0;
                        par_err  <= 1'b0;
                        stop_err <= 1'b0;
                    end
                end
                ST_START: begin
                    if (tick_i && tick_cnt == MID_START) begin
                        tick_cnt <= '0;
                        state    <= rx_i ? ST_IDLE : ST_DATA;  // high again means a glitch
                    end
                end
                ST_DATA: begin
                    if (bit_tick) begin
                        tick_cnt       <= '0;
                        shreg[bit_cnt] <= rx_i;    // lsb first
                        par_acc        <= par_acc ^ rx_i;
                        bit_cnt        <= bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) begin
                            state <= cfg_q.parity_en ? ST_PARITY : ST_STOP;
                        end
                    end
                end
                ST_PARITY: begin
                    if (bit_tick) begin
                        tick_cnt <= '0;
                        par_err  <= rx_i != (par_acc ^ cfg_q.parity_type);
                        state    <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (bit_tick) begin
                        tick_cnt <= '0;
                        if (cfg_q.stop_bits && !stop_cnt) begin
                            stop_cnt <= 1'b1;      // first of two
                            stop_err <= !rx_i;
                        end else begin
                            frame_valid_o      <= 1'b1;
                            frame_o.data       <= shreg;
                            frame_o.parity_err <= par_err;
                            frame_o.stop_err   <= stop_err | !rx_i;
                            state              <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_valid_single: assert property (
        @(posedge clk) disable iff (!reset_n)
        frame_valid_o |=> !frame_valid_o
    ) else $error("frame_valid_o high two cycles in a row");

    a_bit_cnt_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        (state == ST_DATA) |-> (bit_cnt <= last_bit)
    ) else $error("bit counter beyond configured data bits");

endmodule

/* receiver_fifo.sv */
module receiver_fifo
    import uart_rx_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        clear_i,
    input  logic        push_i,
    input  logic [7:0]  wr_data_i,
    input  logic        pop_i,
    input  trig_level_t trig_level_i,
    output logic [7:0]  rd_data_o,
    output logic        rd_valid_o,
    output logic        empty_o,
    output logic        full_o,
    output logic        triggered_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    if (DEPTH < 8 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("receiver_fifo: DEPTH must be a power of two of at least 8");
    end

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] threshold;
    logic          do_push;
    logic          do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));
    assign do_push = push_i && !full_o;   // push on full is dropped
    assign do_pop  = pop_i && !empty_o;

    always_comb begin
        case (trig_level_i)
            TRIG_QUARTER:   threshold = CW'(DEPTH / 4);
            TRIG_HALF:      threshold = CW'(DEPTH / 2);
            TRIG_NEAR_FULL: threshold = CW'(DEPTH - 2);
            default:        threshold = CW'(1);
        endcase
    end

    assign triggered_o = (count >= threshold);

    // ------------------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (do_pop) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= do_pop && !clear_i;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!reset_n)
        count <= CW'(DEPTH)
    ) else $error("fifo count above DEPTH");

endmodule

/* rx_host_port.sv */
module rx_host_port
    import uart_rx_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        fifo_en_i,
    input  logic        hf_en_i,
    input  logic        force_rts_i,
    input  trig_level_t trig_level_i,
    input  rx_frame_t   frame_i,
    input  logic        frame_valid_i,
    input  logic [7:0]  fifo_rd_data_i,
    input  logic        fifo_rd_valid_i,
    input  logic        fifo_empty_i,
    input  logic        fifo_full_i,
    input  logic        fifo_triggered_i,
    output logic        push_o,
    output logic [7:0]  data_o,
    output logic        data_o_valid,
    output logic        parity_err_o,
    output logic        stop_bit_err_o,
    output logic        fifo_rx_overrun_o,
    output logic        rts_no
);

    logic near_full;

    assign near_full = (trig_level_i == TRIG_NEAR_FULL);

    // ------------------------------------------------------------------------
    // data routing
    // ------------------------------------------------------------------------

    assign push_o            = fifo_en_i && frame_valid_i;
    assign fifo_rx_overrun_o = fifo_en_i && fifo_full_i && frame_valid_i;
    assign parity_err_o      = frame_i.parity_err;
    assign stop_bit_err_o    = frame_i.stop_err;

    always_comb begin
        if (fifo_en_i) begin
            data_o       = fifo_rd_data_i;
            data_o_valid = fifo_rd_valid_i;
        end else begin
            data_o       = frame_i.data;     // bypass
            data_o_valid = frame_valid_i;
        end
    end

    // ------------------------------------------------------------------------
    // rts flow control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rts_no <= 1'b0;
        end else if (hf_en_i) begin
            if (force_rts_i) begin
                rts_no <= 1'b0;
            end else if (fifo_triggered_i) begin
                rts_no <= 1'b1;
            end else if (near_full || fifo_empty_i) begin
                rts_no <= 1'b0;                // hysteresis below near-full
            end
        end
    end

    a_rts_hold: assert property (
        @(posedge clk) disable iff (!reset_n)
        !hf_en_i |=> $stable(rts_no)
    ) else $error("rts_no changed with hf_en_i low");

endmodule

/* uart_rx_top.sv */
module uart_rx_top
    import uart_rx_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rx_en_i,
    input  logic       tick_i,
    input  logic       parity_type_i,
    input  logic       parity_en_i,
    input  logic       rx_i,
    input  logic       fifo_rx_reset_i,
    input  logic       stop_bit_num_i,
    input  logic [1:0] data_bit_num_i,
    input  logic       fifo_en_i,
    input  logic       force_rts_i,
    input  logic       fifo_rx_pop_i,
    input  logic [1:0] fifo_rx_trig_level_i,
    input  logic       hf_en_i,
    output logic [7:0] data_o,
    output logic       data_o_valid,
    output logic       parity_err_o,
    output logic       stop_bit_err_o,
    output logic       fifo_rx_overrun_o,
    output logic       rts_no
);

    uart_cfg_t   cfg;
    trig_level_t trig_level;
    rx_frame_t   frame;
    logic        frame_valid;
    logic        fifo_push;
    logic [7:0]  fifo_rd_data;
    logic        fifo_rd_valid;
    logic        fifo_empty;
    logic        fifo_full;
    logic        fifo_triggered;

    assign cfg = '{
        parity_en:   parity_en_i,
        parity_type: parity_type_i,
        stop_bits:   stop_bit_num_i,
        data_bits:   data_bit_num_i
    };
    assign trig_level = trig_level_t'(fifo_rx_trig_level_i);

    uart_receiver u_receiver (
        .clk           (clk),
        .reset_n       (reset_n),
        .rx_en_i       (rx_en_i),
        .tick_i        (tick_i),
        .cfg_i         (cfg),
        .rx_i          (rx_i),
        .frame_o       (frame),
        .frame_valid_o (frame_valid)
    );

    receiver_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .clk          (clk),
        .reset_n      (reset_n),
        .clear_i      (fifo_rx_reset_i),
        .push_i       (fifo_push),
        .wr_data_i    (frame.data),
        .pop_i        (fifo_rx_pop_i),
        .trig_level_i (trig_level),
        .rd_data_o    (fifo_rd_data),
        .rd_valid_o   (fifo_rd_valid),
        .empty_o      (fifo_empty),
        .full_o       (fifo_full),
        .triggered_o  (fifo_triggered)
    );

    rx_host_port u_host_port (
        .clk               (clk),
        .reset_n           (reset_n),
        .fifo_en_i         (fifo_en_i),
        .hf_en_i           (hf_en_i),
        .force_rts_i       (force_rts_i),
        .trig_level_i      (trig_level),
        .frame_i           (frame),
        .frame_valid_i     (frame_valid),
        .fifo_rd_data_i    (fifo_rd_data),
        .fifo_rd_valid_i   (fifo_rd_valid),
        .fifo_empty_i      (fifo_empty),
        .fifo_full_i       (fifo_full),
        .fifo_triggered_i  (fifo_triggered),
        .push_o            (fifo_push),
        .data_o            (data_o),
        .data_o_valid      (data_o_valid),
        .parity_err_o      (parity_err_o),
        .stop_bit_err_o    (stop_bit_err_o),
        .fifo_rx_overrun_o (fifo_rx_overrun_o),
        .rts_no            (rts_no)
    );

endmodule

/* tb_uart_rx_top.sv */
module tb_uart_rx_top
    import uart_rx_pkg::*;
();

    localparam int DEPTH    = 16;
    localparam int N_BYPASS = 24;
    localparam int N_FRAMES = N_BYPASS + 18 + (DEPTH + 4) + 3
                            + (1 + DEPTH / 4 + DEPTH / 2 + DEPTH - 2);

    logic       clk, reset_n, rx_en_i, tick_i, rx_i;
    logic       parity_type_i, parity_en_i, stop_bit_num_i;
    logic       fifo_rx_reset_i, fifo_en_i, force_rts_i, fifo_rx_pop_i, hf_en_i;
    logic [1:0] data_bit_num_i, fifo_rx_trig_level_i;
    logic [7:0] data_o;
    logic       data_o_valid, parity_err_o, stop_bit_err_o, fifo_rx_overrun_o, rts_no;

    logic [31:0] rng;
    logic [1:0]  tick_div;
    logic [7:0]  exp_q[$];          // fifo content model
    logic [7:0]  got_q[$];          // bytes seen on data_o
    int          ovr_cnt;
    logic        rts_m;             // expected rts_no

    uart_rx_top #(.DEPTH(DEPTH)) DUT (.*);

    function automatic int unsigned draw(input int unsigned n);
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng % n;
    endfunction

    function automatic int threshold(input logic [1:0] lvl);
        return (lvl == 2'd0) ? 1 :
               (lvl == 2'd1) ? DEPTH / 4 :
               (lvl == 2'd2) ? DEPTH / 2 : DEPTH - 2;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    // rts_no follows a count or control change within two edges
    task automatic verify_rts(input string name);
        repeat (2) @(negedge clk);
        if (hf_en_i) begin
            if (force_rts_i)
                rts_m = 1'b0;
            else if (exp_q.size() >= threshold(fifo_rx_trig_level_i))
                rts_m = 1'b1;
            else if (fifo_rx_trig_level_i == TRIG_NEAR_FULL || exp_q.size() == 0)
                rts_m = 1'b0;
        end
        check_value(name, rts_m, rts_no);
    endtask

    task automatic drive_bit(input logic value);
        rx_i = value;
        repeat (OVERSAMPLE * 4) @(negedge clk);    // one tick every fourth clock
    endtask

    task automatic send_frame(input logic bad_par, input logic bad_stop,
                              output logic [7:0] sent);
        logic [7:0] value;
        logic       par;
        value          = 8'(draw(256));
        data_bit_num_i = 2'(draw(4));
        parity_en_i    = 1'(draw(2));
        parity_type_i  = 1'(draw(2));
        stop_bit_num_i = 1'(draw(2));
        sent = '0;
        par  = parity_type_i;                       // odd parity starts at one
        drive_bit(1'b0);
        for (int i = 0; i < 5 + data_bit_num_i; i++) begin
            sent[i] = value[i];
            par     = par ^ value[i];
            drive_bit(value[i]);
        end
        if (parity_en_i)
            drive_bit(par ^ bad_par);
        if (stop_bit_num_i)
            drive_bit(1'b1);
        drive_bit(!bad_stop);                       // last stop bit
        rx_i = 1'b1;
        repeat (2 + draw(16)) @(negedge clk);
    endtask

    task automatic fifo_frame();
        logic [7:0] sent;
        int         overruns;
        overruns = ovr_cnt;
        send_frame(1'b0, 1'b0, sent);
        if (rx_en_i && exp_q.size() == DEPTH) begin
            check_value("overrun pulse", overruns + 1, ovr_cnt);
        end else begin
            check_value("no overrun", overruns, ovr_cnt);
            if (rx_en_i)
                exp_q.push_back(sent);
        end
        check_value("valid without pop", 0, got_q.size());
        verify_rts("rts after frame");
    endtask

    task automatic pop_and_check(input string name);
        logic [7:0] expected;
        fifo_rx_pop_i = 1'b1;
        @(negedge clk);
        fifo_rx_pop_i = 1'b0;
        @(negedge clk);                             // valid sampled one cycle after pop
        if (exp_q.size() == 0) begin
            check_value({name, " empty pop"}, 0, got_q.size());
        end else begin
            expected = exp_q.pop_front();
            check_value({name, " valid count"}, 1, got_q.size());
            check_value({name, " data"}, expected, got_q.pop_front());
        end
        verify_rts({name, " rts"});
        repeat (draw(4)) @(negedge clk);
    endtask

    initial begin
        clk = 1'b1;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        tick_div <= reset_n ? tick_div + 2'd1 : 2'd0;
        tick_i   <= reset_n && (tick_div == 2'd3);
    end

    // sample one unit after the falling edge
    always @(negedge clk) begin
        #1;
        if (reset_n && data_o_valid)
            got_q.push_back(data_o);
        if (reset_n && fifo_rx_overrun_o)
            ovr_cnt++;
    end

    initial begin
        #(N_FRAMES * 12 * OVERSAMPLE * 4 * 4 * 2);
        $display("Timeout: the test sequence did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [7:0] sent;
        logic       bad_par;
        logic       bad_stop;
        int         n;
        rng      = 32'hb1de;
        tick_i   = 1'b0;
        ovr_cnt  = 0;
        rts_m    = 1'b0;
        reset_n  = 1'b0;
        rx_i     = 1'b1;
        {rx_en_i, parity_type_i, parity_en_i, stop_bit_num_i, data_bit_num_i} = '0;
        {fifo_rx_reset_i, fifo_en_i, force_rts_i, fifo_rx_pop_i, hf_en_i} = '0;
        fifo_rx_trig_level_i = TRIG_1;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_value("reset rts_no", 0, rts_no);
        check_value("reset overrun", 0, fifo_rx_overrun_o);
        check_value("reset data_o_valid", 0, data_o_valid);
        rx_en_i = 1'b1;

        // --------------------------------------------------------------------
        // bypass with random formats and injected errors
        // --------------------------------------------------------------------
        for (int i = 0; i < N_BYPASS; i++) begin
            bad_par  = (draw(4) == 0);
            bad_stop = (draw(4) == 0);
            send_frame(bad_par, bad_stop, sent);
            check_value("bypass valid count", 1, got_q.size());
            check_value("bypass data", sent, got_q.pop_front());
            check_value("parity flag", bad_par && parity_en_i, parity_err_o);
            check_value("stop flag", bad_stop, stop_bit_err_o);
        end

        // --------------------------------------------------------------------
        // fifo order, overrun and fifo reset
        // --------------------------------------------------------------------
        fifo_en_i = 1'b1;
        for (int r = 0; r < 3; r++) begin
            n = 1 + draw(6);
            repeat (n) fifo_frame();
            repeat (n + 1 + draw(2)) pop_and_check("fifo order");
        end
        repeat (DEPTH + 1) fifo_frame();            // last one overruns
        repeat (DEPTH + 1) pop_and_check("overrun drain");
        repeat (3) fifo_frame();
        fifo_rx_reset_i = 1'b1;
        @(negedge clk);
        fifo_rx_reset_i = 1'b0;
        exp_q.delete();
        verify_rts("rts after fifo reset");
        pop_and_check("after fifo reset");

        // --------------------------------------------------------------------
        // rts flow control at each trigger level
        // --------------------------------------------------------------------
        hf_en_i = 1'b1;
        for (int lvl = 0; lvl < 4; lvl++) begin
            fifo_rx_trig_level_i = 2'(lvl);
            verify_rts("rts level change");
            repeat (threshold(2'(lvl))) fifo_frame();
            if (lvl == 2) begin
                force_rts_i = 1'b1;
                verify_rts("rts forced");
                force_rts_i = 1'b0;
                verify_rts("rts released");
                hf_en_i = 1'b0;                     // drain with rts frozen
            end
            while (exp_q.size() > 0)
                pop_and_check("rts drain");
            hf_en_i = 1'b1;
            verify_rts("rts after drain");
        end

        // receiver disabled
        rx_en_i = 1'b0;
        repeat (2) fifo_frame();
        pop_and_check("receiver disabled");
        fifo_en_i = 1'b0;
        send_frame(1'b0, 1'b0, sent);
        check_value("disabled bypass valid", 0, got_q.size());
        $display("Simulation passed");
        $finish;
    end

endmodule

/* src.f */
uart_rx_pkg.sv
uart_receiver.sv
receiver_fifo.sv
rx_host_port.sv
uart_rx_top.sv
tb_uart_rx_top.sv
